// ==== sources.f ====
+incdir+src
src/rv_pkg.sv
src/pc_unit.sv
src/inst_decoder.sv
src/register_file.sv
src/alu.sv
src/load_store_unit.sv
src/rv_core_top.sv
verification/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/pc_unit.sv
      - src/inst_decoder.sv
      - src/register_file.sv
      - src/alu.sv
      - src/load_store_unit.sv
      - src/rv_core_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_rv_core.sv

// ==== verification/tb_rv_core.sv ====
`include "rv_consts.svh"

module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  // instruction words per test: arith, widths, control, random, halt
  localparam int PROG_WORDS = 45 + 13 + 91 + 121 + 5;
  localparam int NUM_TESTS = 5;
  localparam int WATCHDOG_CYCLES = PROG_WORDS * 2 + NUM_TESTS * 16;
  localparam logic [2:0] R_F3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
  localparam logic R_ALT [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};

  logic     clk;
  logic     reset;
  word_t    inst;
  word_t    pc;
  mem_req_t mem_req;
  word_t    mem_rdata;
  logic     halted;

  word_t    imem [word_t];
  word_t    dmem [256];      // byte addresses 0x000 to 0x3ff
  word_t    prog [$];
  mem_req_t store_log [$];
  word_t    exp_addr [$];
  word_t    exp_val [$];
  int       seed = 32'h7a47_23ea;
  int       errors = 0;
  int       failed_tests = 0;

  rv_core_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .inst      (inst),
    .pc        (pc),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always_comb begin
    if (!$isunknown(pc) && imem.exists(pc)) inst = imem[pc];
    else inst = 32'h0000_0013;  // addi x0, x0, 0
  end

  // read data only while the read strobe is up
  assign mem_rdata = mem_req.read ? dmem[mem_req.addr[9:2]] : '0;

  always @(posedge clk) begin
    if (mem_req.write) begin
      for (int k = 0; k < 4; k++) begin
        if (mem_req.wmask[k]) dmem[mem_req.addr[9:2]][8*k +: 8] <= mem_req.wdata[8*k +: 8];
      end
      store_log.push_back(mem_req);
    end
  end

  function automatic word_t fill_word(input word_t addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  // encoders for each instruction format
  function automatic word_t enc_r(input logic alt, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                  input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], opc_store};  // base is x0
  endfunction

  function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs1,
                                  input reg_idx_t rs2, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  // RV32I reference results
  function automatic word_t ref_alu(input logic [2:0] f3, input logic alt, input word_t a,
                                    input word_t b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return sa >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_branch(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic emit(input word_t w);
    prog.push_back(w);
  endtask

  task automatic load_imm(input reg_idx_t rd, input word_t val);
    word_t up;
    up = val + 32'h800;  // addi sign-extends the low part
    emit({up[31:12], rd, opc_lui});
    emit(enc_i(val[11:0], rd, 3'd0, rd, opc_op_imm));
  endtask

  task automatic store_word(input reg_idx_t rs2, input logic [11:0] off);
    emit(enc_s(off, rs2, 3'b010));
  endtask

  task automatic expect_word(input word_t addr, input word_t val);
    exp_addr.push_back(addr);
    exp_val.push_back(val);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic start_test();
    prog.delete();
    exp_addr.delete();
    exp_val.delete();
    for (int i = 0; i < 256; i++) dmem[i] = fill_word(i << 2);
  endtask

  // reset, run until ebreak, then compare expected memory words
  task automatic run_program(input string name);
    int cycles;
    imem.delete();
    foreach (prog[i]) imem[`RESET_PC + 4 * i] = prog[i];
    store_log.delete();
    @(posedge clk);
    reset <= 1'b1;
    repeat (9) begin
      @(posedge clk);
      @(negedge clk);
      check_word({name, " pc in reset"}, `RESET_PC, pc);
      if (mem_req.read || mem_req.write) begin
        $display("%s: memory strobe high during reset", name);
        errors++;
      end
    end
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_word({name, " pc after reset"}, `RESET_PC, pc);
    cycles = 0;
    while (!halted && cycles < 2 * prog.size()) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("%s: core never halted within %0d cycles", name, cycles);
      errors++;
    end
    foreach (exp_addr[i]) begin
      check_word($sformatf("%s @%h", name, exp_addr[i]), exp_val[i], dmem[exp_addr[i][9:2]]);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before) $display("%s: ok", name);
    else begin
      $display("%s: %0d mismatches", name, errors - errs_before);
      failed_tests++;
    end
  endtask

  task automatic test_arith();
    int    e0;
    word_t a;
    word_t b;
    word_t imm;
    word_t addr;
    e0 = errors;
    start_test();
    a = $random(seed);
    b = $random(seed);
    addr = 0;
    load_imm(1, a);
    load_imm(2, b);
    for (int i = 0; i < 10; i++) begin
      emit(enc_r(R_ALT[i], 2, 1, R_F3[i], 3));
      store_word(3, addr[11:0]);
      expect_word(addr, ref_alu(R_F3[i], R_ALT[i], a, b));
      addr += 4;
      if (i == 1) continue;  // no subi
      if (R_F3[i] == 3'd1 || R_F3[i] == 3'd5) imm = {21'b0, R_ALT[i], 5'b0, b[4:0]};
      else imm = {{20{b[11]}}, b[11:0]};
      emit(enc_i(imm[11:0], 1, R_F3[i], 3, opc_op_imm));
      store_word(3, addr[11:0]);
      expect_word(addr, ref_alu(R_F3[i], R_ALT[i], a, imm));
      addr += 4;
    end
    emit(enc_i(12'd5, 1, 3'd0, 0, opc_op_imm));  // write to x0
    store_word(0, addr[11:0]);
    expect_word(addr, 32'h0);
    emit(32'h0010_0073);
    run_program("arith");
    end_test("arith", e0);
  endtask

  task automatic test_widths();
    int       e0;
    word_t    val;
    word_t    w;
    mem_req_t req;
    logic [2:0] lf3 [4] = '{3'b000, 3'b001, 3'b100, 3'b101};
    logic [1:0] loff [4] = '{2'd3, 2'd2, 2'd1, 2'd0};
    e0 = errors;
    start_test();
    val = 32'h1234_56c7;
    load_imm(7, val);
    emit(enc_s(12'h181, 7, 3'b000));  // sb
    emit(enc_s(12'h186, 7, 3'b001));  // sh
    dmem[32'h100 >> 2] = 32'h8a93_f481;
    for (int i = 0; i < 4; i++) begin
      emit(enc_i({10'h040, loff[i]}, 0, lf3[i], 6, opc_load));
      store_word(6, 12'h140 + 4 * i);
      w = 32'h8a93_f481 >> (8 * loff[i]);
      if (lf3[i][0]) w = lf3[i][2] ? {16'b0, w[15:0]} : {{16{w[15]}}, w[15:0]};
      else w = lf3[i][2] ? {24'b0, w[7:0]} : {{24{w[7]}}, w[7:0]};
      expect_word(32'h140 + 4 * i, w);
    end
    w = fill_word(32'h180);
    w[15:8] = val[7:0];
    expect_word(32'h180, w);
    w = fill_word(32'h184);
    w[31:16] = val[15:0];
    expect_word(32'h184, w);
    emit(32'h0010_0073);
    run_program("widths");
    if (store_log.size() < 2) begin
      $display("widths: byte and half stores were not seen on the bus");
      errors++;
    end else begin
      req = '{addr: 32'h181, wdata: val << 8, wmask: 4'b0010, read: 1'b0, write: 1'b1};
      check_mem_req("widths sb", req, store_log[0]);
      req = '{addr: 32'h186, wdata: val << 16, wmask: 4'b1100, read: 1'b0, write: 1'b1};
      check_mem_req("widths sh", req, store_log[1]);
    end
    end_test("widths", e0);
  endtask

  task automatic test_control();
    int       e0;
    int       k;
    word_t    p;
    word_t    regv [3] = '{32'h0, 32'hffff_fffb, 32'd3};
    reg_idx_t ra [3] = '{5'd1, 5'd2, 5'd2};
    reg_idx_t rb [3] = '{5'd2, 5'd1, 5'd2};
    logic [2:0] bf3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    e0 = errors;
    start_test();
    load_imm(1, regv[1]);
    load_imm(2, regv[2]);
    load_imm(9, 32'hbad0_bad0);  // never stored
    load_imm(11, 32'h0000_0a0a);  // not-taken marker
    load_imm(12, 32'h0000_7b7b);  // taken marker
    k = 0;
    foreach (bf3[f]) begin
      for (int c = 0; c < 3; c++) begin
        emit(enc_b(13'd12, ra[c], rb[c], bf3[f]));
        store_word(11, 12'h200 + 8 * k);
        emit(enc_j(21'd8, 0));
        store_word(12, 12'h204 + 8 * k);
        if (ref_branch(bf3[f], regv[ra[c]], regv[rb[c]])) begin
          expect_word(32'h200 + 8 * k, fill_word(32'h200 + 8 * k));
          expect_word(32'h204 + 8 * k, 32'h7b7b);
        end else begin
          expect_word(32'h200 + 8 * k, 32'h0a0a);
          expect_word(32'h204 + 8 * k, fill_word(32'h204 + 8 * k));
        end
        k++;
      end
    end
    p = `RESET_PC + 4 * prog.size();
    emit(enc_j(21'd8, 13));
    store_word(9, 12'h30c);
    store_word(13, 12'h300);
    expect_word(32'h300, p + 4);
    expect_word(32'h30c, fill_word(32'h30c));
    p = `RESET_PC + 4 * prog.size();
    load_imm(14, p + 17);  // odd target, bit 0 must drop
    emit(enc_i(12'd0, 14, 3'd0, 15, opc_jalr));
    store_word(9, 12'h308);
    store_word(15, 12'h304);
    expect_word(32'h304, p + 12);
    expect_word(32'h308, fill_word(32'h308));
    emit(32'h0010_0073);
    run_program("control");
    end_test("control", e0);
  endtask

  task automatic test_random();
    int    e0;
    int    op;
    word_t a;
    word_t b;
    e0 = errors;
    start_test();
    for (int i = 0; i < 20; i++) begin
      a = $random(seed);
      b = $random(seed);
      op = $unsigned($random(seed)) % 10;
      load_imm(1, a);
      load_imm(2, b);
      emit(enc_r(R_ALT[op], 2, 1, R_F3[op], 3));
      store_word(3, 12'h380 + 4 * i);
      expect_word(32'h380 + 4 * i, ref_alu(R_F3[op], R_ALT[op], a, b));
    end
    emit(32'h0010_0073);
    run_program("random");
    end_test("random", e0);
  endtask

  task automatic test_halt();
    int e0;
    e0 = errors;
    start_test();
    store_word(0, 12'h3f4);  // presented on inst while reset is high
    expect_word(32'h3f4, 32'h0);
    load_imm(1, 32'h0000_abcd);
    emit(32'h0010_0073);
    store_word(1, 12'h3f0);  // sits behind the ebreak
    expect_word(32'h3f0, fill_word(32'h3f0));
    run_program("halt");
    repeat (4) @(negedge clk);
    check_word("halt pc", `RESET_PC + 12, pc);
    check_word("halt flag", 32'd1, {31'b0, halted});
    check_word("halt store", fill_word(32'h3f0), dmem[32'h3f0 >> 2]);
    end_test("halt", e0);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * 8ns);
    $display("watchdog expired before all tests finished");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    reset = 1'b1;
    test_arith();
    test_widths();
    test_control();
    test_random();
    test_halt();
    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== src/rv_core_top.sv ====
`include "rv_consts.svh"

module rv_core_top (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::word_t    inst,
  output rv_pkg::word_t    pc,
  output rv_pkg::mem_req_t mem_req,
  input  rv_pkg::word_t    mem_rdata,
  output logic             halted
);
  import rv_pkg::*;

  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t load_data;
  word_t pc_plus4;
  word_t wb_data;
  logic  branch_taken;
  logic  reg_wen;

  pc_unit i_pc_unit (
    .clk          (clk),
    .reset        (reset),
    .ctrl         (ctrl),
    .branch_taken (branch_taken),
    .target       (alu_result),
    .pc           (pc),
    .halted       (halted)
  );

  inst_decoder i_inst_decoder (
    .inst (inst),
    .ctrl (ctrl)
  );

  register_file i_register_file (
    .clk      (clk),
    .rs1_addr (ctrl.rs1),
    .rs2_addr (ctrl.rs2),
    .rd_addr  (ctrl.rd),
    .wdata    (wb_data),
    .wen      (reg_wen),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = ctrl.alu_src_pc ? pc : rs1_data;
  assign alu_b = ctrl.alu_src_imm ? ctrl.imm : rs2_data;

  alu i_alu (
    .op           (ctrl.alu_op),
    .a            (alu_a),
    .b            (alu_b),
    .funct3       (ctrl.funct3),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  load_store_unit i_load_store_unit (
    .reset      (reset),
    .ctrl       (ctrl),
    .addr       (alu_result),
    .store_data (rs2_data),
    .halted     (halted),
    .mem_req    (mem_req),
    .mem_rdata  (mem_rdata),
    .load_data  (load_data)
  );

  assign pc_plus4 = pc + `INST_STEP;  // link value

  always_comb begin
    case (ctrl.wb_sel)
      wb_mem:  wb_data = load_data;
      wb_pc4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  assign reg_wen = ctrl.reg_write && !halted;  // frozen after ebreak

endmodule

// ==== src/load_store_unit.sv ====
`include "rv_consts.svh"

module load_store_unit (
  input  logic             reset,
  input  rv_pkg::ctrl_t    ctrl,
  input  rv_pkg::word_t    addr,        // byte address from the alu
  input  rv_pkg::word_t    store_data,  // rs2
  input  logic             halted,
  output rv_pkg::mem_req_t mem_req,
  input  rv_pkg::word_t    mem_rdata,
  output rv_pkg::word_t    load_data
);
  import rv_pkg::*;

  logic [1:0]         offset;
  logic [4:0]         lane_shift;  // offset in bits
  logic [`MASK_W-1:0] mask;
  logic               active;
  word_t              lane_data;

  assign offset     = addr[1:0];
  assign lane_shift = {offset, 3'b000};
  assign active     = !reset && !halted;

  // byte, half or full word mask
  always_comb begin
    case (ctrl.funct3[1:0])
      2'b00:   mask = `MASK_W'(4'b0001) << offset;
      2'b01:   mask = `MASK_W'(4'b0011) << offset;
      default: mask = '1;
    endcase
  end

  always_comb begin
    mem_req       = '0;
    mem_req.addr  = addr;
    mem_req.wdata = store_data << lane_shift;
    mem_req.wmask = mask;
    mem_req.read  = ctrl.mem_read && active;
    mem_req.write = ctrl.mem_write && active;
  end

  // bring the addressed lane down to bit 0
  assign lane_data = mem_rdata >> lane_shift;

  always_comb begin
    case (ctrl.funct3)
      3'b000:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};    // lb
      3'b001:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};  // lh
      3'b100:  load_data = {24'b0, lane_data[7:0]};                 // lbu
      3'b101:  load_data = {16'b0, lane_data[15:0]};                // lhu
      default: load_data = mem_rdata;                               // lw
    endcase
  end

endmodule

// ==== src/alu.sv ====
module alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  logic [2:0]      funct3,    // branch kind
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  output rv_pkg::word_t   result,
  output logic            branch_taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = word_t'($signed(a) < $signed(b));
      alu_sltu:   result = word_t'(a < b);
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $signed(a) >>> shamt;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = a + b;
    endcase
  end

  // branch compare always looks at the two register values
  assign eq   = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (funct3)
      3'b000:  branch_taken = eq;     // beq
      3'b001:  branch_taken = !eq;    // bne
      3'b100:  branch_taken = lt_s;   // blt
      3'b101:  branch_taken = !lt_s;  // bge
      3'b110:  branch_taken = lt_u;   // bltu
      3'b111:  branch_taken = !lt_u;  // bgeu
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== src/register_file.sv ====
`include "rv_consts.svh"

module register_file (
  input  logic             clk,
  input  rv_pkg::reg_idx_t rs1_addr,
  input  rv_pkg::reg_idx_t rs2_addr,
  input  rv_pkg::reg_idx_t rd_addr,
  input  rv_pkg::word_t    wdata,
  input  logic             wen,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [`NUM_REGS];  // entry 0 is never written

  logic write_ok;

  assign write_ok = wen && (rd_addr != '0);

  always_ff @(posedge clk) begin
    if (write_ok) begin
      regs[rd_addr] <= wdata;
    end
  end

  // asynchronous read, x0 forced to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== src/inst_decoder.sv ====
module inst_decoder (
  input  rv_pkg::word_t inst,
  output rv_pkg::ctrl_t ctrl
);
  import rv_pkg::*;

  localparam word_t EBREAK_INST = 32'h0010_0073;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       alt;     // funct7 bit 5, sub / sra
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  // funct3 to alu operation, shared by op and op-imm
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sel_alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = sel_alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = sel_alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign alt    = inst[30];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;  // no writes unless an opcode asks for them
    ctrl.rs1    = inst[19:15];
    ctrl.rs2    = inst[24:20];
    ctrl.rd     = inst[11:7];
    ctrl.funct3 = funct3;
    ctrl.alu_op = alu_add;
    ctrl.wb_sel = wb_alu;

    case (opcode)
      opc_lui: begin
        ctrl.imm         = imm_u;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_pass_b;
        ctrl.reg_write   = 1'b1;
      end
      opc_auipc: begin
        ctrl.imm         = imm_u;
        ctrl.alu_src_pc  = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      opc_jal: begin
        ctrl.imm         = imm_j;
        ctrl.alu_src_pc  = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.is_jal      = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.wb_sel      = wb_pc4;
      end
      opc_jalr: begin
        ctrl.imm         = imm_i;
        ctrl.alu_src_imm = 1'b1;  // rs1 + imm, bit 0 dropped in pc_unit
        ctrl.is_jalr     = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.wb_sel      = wb_pc4;
      end
      opc_branch: begin
        ctrl.imm         = imm_b;
        ctrl.alu_src_pc  = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.is_branch   = 1'b1;
      end
      opc_load: begin
        ctrl.imm         = imm_i;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.wb_sel      = wb_mem;
      end
      opc_store: begin
        ctrl.imm         = imm_s;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      opc_op_imm: begin
        ctrl.imm         = imm_i;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = arith_op(funct3, (funct3 == 3'b101) && alt);
        ctrl.reg_write   = 1'b1;
      end
      opc_op: begin
        ctrl.alu_op    = arith_op(funct3, alt);
        ctrl.reg_write = 1'b1;
      end
      opc_system: begin
        // ecall and csr forms fall through as no-ops
        ctrl.is_ebreak = (inst == EBREAK_INST);
      end
      default: ;
    endcase
  end

endmodule

// ==== src/pc_unit.sv ====
`include "rv_consts.svh"

module pc_unit (
  input  logic          clk,
  input  logic          reset,
  input  rv_pkg::ctrl_t ctrl,
  input  logic          branch_taken,
  input  rv_pkg::word_t target,       // rs1 + imm from the alu
  output rv_pkg::word_t pc,
  output logic          halted
);
  import rv_pkg::*;

  word_t pc_seq;
  word_t pc_rel;
  word_t pc_next;

  assign pc_seq = pc + `INST_STEP;
  assign pc_rel = pc + ctrl.imm;  // jal and branch target

  always_comb begin
    if (ctrl.is_ebreak) begin
      pc_next = pc;  // stay on the ebreak
    end else if (ctrl.is_jalr) begin
      pc_next = {target[`XLEN-1:1], 1'b0};
    end else if (ctrl.is_jal || (ctrl.is_branch && branch_taken)) begin
      pc_next = pc_rel;
    end else begin
      pc_next = pc_seq;
    end
  end

  // once halted, only reset moves the pc again
  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= `RESET_PC;
      halted <= 1'b0;
    end else if (!halted) begin
      pc     <= pc_next;
      halted <= ctrl.is_ebreak;
    end
  end

endmodule

// ==== src/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    opc_load   = 7'b000_0011,
    opc_store  = 7'b010_0011,
    opc_branch = 7'b110_0011,
    opc_jal    = 7'b110_1111,
    opc_jalr   = 7'b110_0111,
    opc_lui    = 7'b011_0111,
    opc_auipc  = 7'b001_0111,
    opc_op_imm = 7'b001_0011,
    opc_op     = 7'b011_0011,
    opc_system = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b    // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_pc4        // link value for jal / jalr
  } wb_sel_e;

  typedef struct packed {
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm;
    alu_op_e    alu_op;
    logic       alu_src_pc;   // operand a is pc
    logic       alu_src_imm;  // operand b is imm
    logic       reg_write;
    wb_sel_e    wb_sel;
    logic       mem_read;
    logic       mem_write;
    logic [2:0] funct3;       // access size or branch kind
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_ebreak;
  } ctrl_t;

  typedef struct packed {
    word_t              addr;   // byte address
    word_t              wdata;  // already shifted into its lanes
    logic [`MASK_W-1:0] wmask;
    logic               read;
    logic               write;
  } mem_req_t;

endpackage

// ==== src/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path and address width
`define XLEN 32

// architectural integer registers, x0 included
`define NUM_REGS 32

// first fetch address after reset
`define RESET_PC 32'h8000_0000

// pc increment for sequential fetch
`define INST_STEP 32'd4

// store mask covers one byte per lane
`define MASK_W (`XLEN / 8)

`endif
